/* Bender.yml */
package:
  name: fetch_unit

sources:
  - FetchPkg.sv
  - ProgramCounter.sv
  - BranchTargetBuffer.sv
  - InstrMemory.sv
  - FetchUnit.sv
  - target: test
    files:
      - tbFetch_assert.sv
      - tbFetch.sv

/* BranchTargetBuffer.sv */
`timescale 1ns/10ps

module BranchTargetBuffer #(
    parameter int NUM_BTB_ENTRIES = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [FetchPkg::XLEN-1:0]           lookupPc,
    input  logic                                updWrite,
    input  logic [FetchPkg::XLEN-1:0]           updPc,
    input  logic [FetchPkg::XLEN-1:0]           updDst,
    input  logic                                updIsJump,
    input  logic                                updTaken,
    output logic                                branchFound,
    output logic                                branchTaken,
    output logic                                isJump,
    output logic [FetchPkg::XLEN-1:0]           branchSrc,
    output logic [FetchPkg::XLEN-1:0]           branchDst,
    output logic [FetchPkg::BRANCH_ID_W-1:0]    branchId,
    output logic                                multipleBranches
);
    import FetchPkg::*;

    localparam int IDX_W = (NUM_BTB_ENTRIES > 1) ? $clog2(NUM_BTB_ENTRIES) : 1;
    localparam int TAG_W = XLEN - 3 - IDX_W;

    logic [TAG_W-1:0] entTag [NUM_BTB_ENTRIES];
    logic [1:0]       entValid [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]  entDst [NUM_BTB_ENTRIES][2];
    logic [1:0]       entJump [NUM_BTB_ENTRIES];
    logic [1:0]       entTaken [NUM_BTB_ENTRIES];

    logic [IDX_W-1:0] lkIdx;
    logic [TAG_W-1:0] lkTag;
    logic             lkHit;
    logic             slot0Hit;
    logic             slot1Hit;
    logic             sel;
    logic [IDX_W-1:0] updIdx;
    logic [TAG_W-1:0] updTag;
    logic             updSlot;
    logic             updOk;
    logic             updSameTag;

    // lookup
    assign lkIdx = lookupPc[3 +: IDX_W];
    assign lkTag = lookupPc[XLEN-1 -: TAG_W];
    assign lkHit = (int'(lkIdx) < NUM_BTB_ENTRIES) && (entTag[lkIdx] == lkTag);
    // slot 0 only counts when fetch enters at the lower half
    assign slot0Hit = lkHit && entValid[lkIdx][0] && !lookupPc[2];
    assign slot1Hit = lkHit && entValid[lkIdx][1];
    assign sel = !slot0Hit;

    assign branchFound = slot0Hit || slot1Hit;
    assign branchTaken = entTaken[lkIdx][sel];
    assign isJump = entJump[lkIdx][sel];
    assign branchSrc = {lookupPc[XLEN-1:3], sel, 2'b00};
    assign branchDst = entDst[lkIdx][sel];
    assign branchId = BRANCH_ID_W'({lkIdx, sel});
    assign multipleBranches = slot0Hit && !entTaken[lkIdx][0] && slot1Hit;

    // update
    assign updIdx = updPc[3 +: IDX_W];
    assign updTag = updPc[XLEN-1 -: TAG_W];
    assign updSlot = updPc[2];
    assign updOk = updWrite && (int'(updIdx) < NUM_BTB_ENTRIES);
    assign updSameTag = (entTag[updIdx] == updTag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < NUM_BTB_ENTRIES; e++) begin
                entValid[e] <= 2'b00;
            end
        end else if (updOk) begin
            // new bundle replaces the line, old slots go
            entValid[updIdx] <= (updSameTag ? entValid[updIdx] : 2'b00) | (2'b01 << updSlot);
        end
    end

    always_ff @(posedge clk) begin
        if (updOk) begin
            entTag[updIdx] <= updTag;
            entDst[updIdx][updSlot] <= updDst;
            entJump[updIdx][updSlot] <= updIsJump;
            // jumps always stored as taken
            entTaken[updIdx][updSlot] <= updTaken || updIsJump;
        end
    end

endmodule

/* FetchPkg.sv */
package FetchPkg;

    // address and PC width
    localparam int XLEN = 32;

    localparam int INSTR_W = 32;

    // one fetch bundle carries two instruction slots
    localparam int BUNDLE_W = 2 * INSTR_W;

    localparam int BRANCH_ID_W = 6;

    // slot holds no predicted branch
    localparam logic [BRANCH_ID_W-1:0] NO_BRANCH_ID = 6'd63;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

endpackage

/* FetchUnit.sv */
`timescale 1ns/10ps

module FetchUnit #(
    parameter int NUM_UOPS = 2,
    parameter int NUM_BTB_ENTRIES = 16,
    parameter int MEM_WORDS = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en0,
    input  logic                                en1,
    input  logic                                write,
    input  logic [FetchPkg::XLEN-1:0]           writePc,
    input  logic                                memWrite,
    input  logic [$clog2(MEM_WORDS)-1:0]        memAddr,
    input  logic [FetchPkg::BUNDLE_W-1:0]       memData,
    input  logic                                btbWrite,
    input  logic [FetchPkg::XLEN-1:0]           btbPc,
    input  logic [FetchPkg::XLEN-1:0]           btbDst,
    input  logic                                btbIsJump,
    input  logic                                btbTaken,
    output logic [FetchPkg::XLEN-1:0]           pcRaw,
    output logic [FetchPkg::XLEN-1:0]           outPc [NUM_UOPS],
    output logic [FetchPkg::INSTR_W-1:0]        outInstr [NUM_UOPS],
    output logic [FetchPkg::BRANCH_ID_W-1:0]    outBranchId [NUM_UOPS],
    output logic                                outBranchPred [NUM_UOPS],
    output logic                                outValid [NUM_UOPS]
);
    import FetchPkg::*;

    logic                   branchFound;
    logic                   branchTaken;
    logic                   isJump;
    logic [XLEN-1:0]        branchSrc;
    logic [XLEN-1:0]        branchDst;
    logic [BRANCH_ID_W-1:0] branchId;
    logic                   multipleBranches;
    logic [XLEN-1:0]        fetchAddr;
    logic [BUNDLE_W-1:0]    bundle;

    ProgramCounter #(
        .NUM_UOPS(NUM_UOPS)
    ) u_ProgramCounter (
        .clk(clk),
        .rst(rst),
        .en0(en0),
        .en1(en1),
        .writePc(writePc),
        .write(write),
        .instr(bundle),
        .branchFound(branchFound),
        .branchTaken(branchTaken),
        .isJump(isJump),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .branchId(branchId),
        .multipleBranches(multipleBranches),
        .pcRaw(pcRaw),
        .fetchAddr(fetchAddr),
        .pc(outPc),
        .slotInstr(outInstr),
        .slotBranchId(outBranchId),
        .slotBranchPred(outBranchPred),
        .slotValid(outValid)
    );

    // lookup runs on the live PC
    BranchTargetBuffer #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)
    ) u_BranchTargetBuffer (
        .clk(clk),
        .rst(rst),
        .lookupPc(pcRaw),
        .updWrite(btbWrite),
        .updPc(btbPc),
        .updDst(btbDst),
        .updIsJump(btbIsJump),
        .updTaken(btbTaken),
        .branchFound(branchFound),
        .branchTaken(branchTaken),
        .isJump(isJump),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .branchId(branchId),
        .multipleBranches(multipleBranches)
    );

    InstrMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) u_InstrMemory (
        .clk(clk),
        .en(en1),
        .rdAddr(fetchAddr),
        .ldWrite(memWrite),
        .ldAddr(memAddr),
        .ldData(memData),
        .bundle(bundle)
    );

endmodule

/* InstrMemory.sv */
`timescale 1ns/10ps

module InstrMemory #(
    parameter int MEM_WORDS = 64
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic [FetchPkg::XLEN-1:0]       rdAddr,
    input  logic                            ldWrite,
    input  logic [$clog2(MEM_WORDS)-1:0]    ldAddr,
    input  logic [FetchPkg::BUNDLE_W-1:0]   ldData,
    output logic [FetchPkg::BUNDLE_W-1:0]   bundle
);
    import FetchPkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [BUNDLE_W-1:0] mem [MEM_WORDS];
    logic [AW-1:0]       rdIdx;

    // byte address down to a bundle index
    assign rdIdx = rdAddr[3 +: AW];

    always_ff @(posedge clk) begin
        if (ldWrite) begin
            mem[ldAddr] <= ldData;
        end
    end

    // holds the last bundle while the output stage stalls
    always_ff @(posedge clk) begin
        if (en) begin
            bundle <= mem[rdIdx];
        end
    end

endmodule

/* ProgramCounter.sv */
`timescale 1ns/10ps

module ProgramCounter #(
    parameter int NUM_UOPS = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en0,
    input  logic                                en1,
    input  logic [FetchPkg::XLEN-1:0]           writePc,
    input  logic                                write,
    input  logic [FetchPkg::BUNDLE_W-1:0]       instr,
    input  logic                                branchFound,
    input  logic                                branchTaken,
    input  logic                                isJump,
    input  logic [FetchPkg::XLEN-1:0]           branchSrc,
    input  logic [FetchPkg::XLEN-1:0]           branchDst,
    input  logic [FetchPkg::BRANCH_ID_W-1:0]    branchId,
    input  logic                                multipleBranches,
    output logic [FetchPkg::XLEN-1:0]           pcRaw,
    output logic [FetchPkg::XLEN-1:0]           fetchAddr,
    output logic [FetchPkg::XLEN-1:0]           pc [NUM_UOPS],
    output logic [FetchPkg::INSTR_W-1:0]        slotInstr [NUM_UOPS],
    output logic [FetchPkg::BRANCH_ID_W-1:0]    slotBranchId [NUM_UOPS],
    output logic                                slotBranchPred [NUM_UOPS],
    output logic                                slotValid [NUM_UOPS]
);
    import FetchPkg::*;

    // PC in half-words, bit 1 selects the slot
    logic [XLEN-2:0]        pcHw;
    logic [XLEN-2:0]        pcLast;
    logic [NUM_UOPS-1:0]    maskLast;
    logic [BRANCH_ID_W-1:0] idLast [NUM_UOPS];
    logic                   predLast [NUM_UOPS];
    logic [XLEN-2:0]        pcSeq;
    logic                   takenFound;

    assign pcRaw = {pcHw, 1'b0};
    assign fetchAddr = {pcLast[XLEN-2:2], 3'b000};

    // start of the next aligned bundle
    assign pcSeq = {pcHw[XLEN-2:2] + 1'b1, 2'b00};
    assign takenFound = branchFound && (branchTaken || isJump);

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            slotInstr[i] = instr[i*INSTR_W +: INSTR_W];
        end
    end

    // PC stage
    always_ff @(posedge clk) begin
        if (rst) begin
            pcHw <= RESET_PC[XLEN-1:1];
            maskLast <= '0;
        end else if (write) begin
            pcHw <= writePc[XLEN-1:1];
            // bundle waiting in pcLast belongs to the old path
            maskLast <= '0;
        end else if (en0) begin
            pcLast <= pcHw;
            if (takenFound) begin
                pcHw <= branchDst[XLEN-1:1];
                if (branchSrc[2]) begin
                    // taken slot 1, both slots run
                    maskLast <= 2'b11;
                    idLast[0] <= NO_BRANCH_ID;
                    idLast[1] <= branchId;
                    predLast[0] <= 1'b0;
                    predLast[1] <= 1'b1;
                end else begin
                    maskLast <= 2'b01;
                    idLast[0] <= branchId;
                    idLast[1] <= NO_BRANCH_ID;
                    predLast[0] <= 1'b1;
                    predLast[1] <= 1'b0;
                end
            end else if (branchFound) begin
                // conditional branches predicted not taken
                predLast[0] <= 1'b0;
                predLast[1] <= 1'b0;
                if (multipleBranches) begin
                    // re-enter the bundle at slot 1 to look up its branch
                    pcHw <= branchSrc[XLEN-1:1] + 2'd2;
                    maskLast <= 2'b01;
                end else begin
                    pcHw <= pcSeq;
                    maskLast <= 2'b11;
                end
                if (branchSrc[2]) begin
                    idLast[0] <= NO_BRANCH_ID;
                    idLast[1] <= branchId;
                end else begin
                    idLast[0] <= branchId;
                    idLast[1] <= NO_BRANCH_ID;
                end
            end else begin
                pcHw <= pcSeq;
                maskLast <= 2'b11;
                idLast[0] <= NO_BRANCH_ID;
                idLast[1] <= NO_BRANCH_ID;
                predLast[0] <= 1'b0;
                predLast[1] <= 1'b0;
            end
        end
    end

    // output stage, in step with the memory read
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                slotValid[i] <= 1'b0;
            end
        end else if (en1) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                pc[i] <= {pcLast[XLEN-2:2], 3'b000} + XLEN'(4 * i);
                // slots before the entry half are skipped
                slotValid[i] <= (i >= int'(pcLast[1])) && maskLast[i];
                slotBranchId[i] <= idLast[i];
                slotBranchPred[i] <= predLast[i];
            end
        end
    end

endmodule

/* src.f */
FetchPkg.sv
ProgramCounter.sv
BranchTargetBuffer.sv
InstrMemory.sv
FetchUnit.sv
tbFetch_assert.sv
tbFetch.sv

/* tbFetch.sv */
`timescale 1ns/10ps

module tbFetch;
    import FetchPkg::*;

    localparam int NUM_BTB_ENTRIES = 16;
    localparam int MEM_WORDS = 64;
    // about twice the full sequence including the longest stalls
    localparam int MAX_CYCLES = 400;

    logic                   clk;
    logic                   rst;
    logic                   en0;
    logic                   en1;
    logic                   write;
    logic [XLEN-1:0]        writePc;
    logic                   memWrite;
    logic [5:0]             memAddr;
    logic [BUNDLE_W-1:0]    memData;
    logic                   btbWrite;
    logic [XLEN-1:0]        btbPc;
    logic [XLEN-1:0]        btbDst;
    logic                   btbIsJump;
    logic                   btbTaken;
    logic [XLEN-1:0]        pcRaw;
    logic [XLEN-1:0]        outPc [2];
    logic [INSTR_W-1:0]     outInstr [2];
    logic [BRANCH_ID_W-1:0] outBranchId [2];
    logic                   outBranchPred [2];
    logic                   outValid [2];

    logic [BUNDLE_W-1:0]    tbMem [MEM_WORDS];
    integer                 seed;
    int                     cycleCount;
    int                     stallLen;
    logic [XLEN-1:0]        expPc;

    FetchUnit #(
        .NUM_UOPS(2),
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES),
        .MEM_WORDS(MEM_WORDS)
    ) u_FetchUnit (
        .clk(clk),
        .rst(rst),
        .en0(en0),
        .en1(en1),
        .write(write),
        .writePc(writePc),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memData(memData),
        .btbWrite(btbWrite),
        .btbPc(btbPc),
        .btbDst(btbDst),
        .btbIsJump(btbIsJump),
        .btbTaken(btbTaken),
        .pcRaw(pcRaw),
        .outPc(outPc),
        .outInstr(outInstr),
        .outBranchId(outBranchId),
        .outBranchPred(outBranchPred),
        .outValid(outValid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bundle index wrapping over the memory
    function automatic int memIndex(input logic [XLEN-1:0] addr);
        return (addr >> 3) % MEM_WORDS;
    endfunction

    // BTB index times two plus the slot
    function automatic logic [BRANCH_ID_W-1:0] branchIdFor(input logic [XLEN-1:0] addr);
        return BRANCH_ID_W'(((addr >> 3) % NUM_BTB_ENTRIES) * 2 + addr[2]);
    endfunction

    task automatic failValue(input string testName, input string what,
                             input logic [31:0] expVal, input logic [31:0] actVal);
        $display("** Error [%s] %s: expected %h, actual %h", testName, what, expVal, actVal);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic checkEq(input string testName, input string what,
                           input logic [31:0] expVal, input logic [31:0] actVal);
        assert (actVal === expVal) else failValue(testName, what, expVal, actVal);
    endtask

    task automatic waitCycle();
        @(negedge clk);
    endtask

    task automatic checkBundle(input string testName, input logic [XLEN-1:0] pc0,
                               input logic v0, input logic v1,
                               input logic [BRANCH_ID_W-1:0] id0,
                               input logic [BRANCH_ID_W-1:0] id1,
                               input logic p0, input logic p1);
        logic                   expV [2];
        logic [BRANCH_ID_W-1:0] expId [2];
        logic                   expPred [2];
        logic [BUNDLE_W-1:0]    word;
        expV[0] = v0;
        expV[1] = v1;
        expId[0] = id0;
        expId[1] = id1;
        expPred[0] = p0;
        expPred[1] = p1;
        word = tbMem[memIndex(pc0)];
        checkEq(testName, "slot 0 pc", pc0, outPc[0]);
        checkEq(testName, "slot 1 pc", pc0 + 32'd4, outPc[1]);
        for (int i = 0; i < 2; i++) begin
            checkEq(testName, $sformatf("slot %0d valid", i), 32'(expV[i]), 32'(outValid[i]));
            if (expV[i]) begin
                checkEq(testName, $sformatf("slot %0d instr", i), word[i*32 +: 32], outInstr[i]);
                checkEq(testName, $sformatf("slot %0d id", i), 32'(expId[i]),
                    32'(outBranchId[i]));
                checkEq(testName, $sformatf("slot %0d pred", i), 32'(expPred[i]),
                    32'(outBranchPred[i]));
            end
        end
    endtask

    task automatic writeBtb(input logic [XLEN-1:0] srcPc, input logic [XLEN-1:0] dst,
                            input logic jump, input logic taken);
        btbWrite = 1'b1;
        btbPc = srcPc;
        btbDst = dst;
        btbIsJump = jump;
        btbTaken = taken;
        waitCycle();
        btbWrite = 1'b0;
    endtask

    // cycle limit and bound checker watch
    initial begin
        cycleCount = 0;
        while (!u_FetchUnit.u_fetchChecks.failFlag && cycleCount < MAX_CYCLES) begin
            @(negedge clk);
            cycleCount++;
        end
        if (u_FetchUnit.u_fetchChecks.failFlag) begin
            $display("a bound assertion failed at cycle %0d", cycleCount);
        end else begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        end
        $display("TB FAILED");
        $fatal(1, "run aborted");
    end

    initial begin
        seed = 32'h5c9ffd74;
        rst = 1'b1;
        en0 = 1'b0;
        en1 = 1'b0;
        write = 1'b0;
        writePc = '0;
        memWrite = 1'b0;
        memAddr = '0;
        memData = '0;
        btbWrite = 1'b0;
        btbPc = '0;
        btbDst = '0;
        btbIsJump = 1'b0;
        btbTaken = 1'b0;
        repeat (5) @(posedge clk);
        waitCycle();
        rst = 1'b0;

        for (int k = 0; k < MEM_WORDS; k++) begin
            tbMem[k] = {32'($random(seed)), (32'(k) * 32'h9e37_79b9) ^ 32'h0bad_f00d};
            memWrite = 1'b1;
            memAddr = 6'(k);
            memData = tbMem[k];
            waitCycle();
        end
        memWrite = 1'b0;

        // branch entries carry nonzero tags away from the sequential run
        writeBtb(32'h10C, 32'h140, 1'b1, 1'b0);
        writeBtb(32'h140, 32'h1A0, 1'b0, 1'b1);
        writeBtb(32'h1A0, 32'h300, 1'b0, 1'b0);
        writeBtb(32'h1A4, 32'h300, 1'b0, 1'b0);

        en0 = 1'b1;
        en1 = 1'b1;
        // first output edge still shows the empty pipeline
        waitCycle();
        for (int j = 0; j < 10; j++) begin
            waitCycle();
            checkBundle("sequential", 32'(8 * j), 1'b1, 1'b1, NO_BRANCH_ID, NO_BRANCH_ID, 0, 0);
            checkEq("sequential", "pcRaw", 32'(8 * j + 16), pcRaw);
        end

        write = 1'b1;
        writePc = 32'h104;
        waitCycle();
        write = 1'b0;
        checkBundle("redirect", 32'h50, 1'b1, 1'b1, NO_BRANCH_ID, NO_BRANCH_ID, 0, 0);
        checkEq("redirect", "pcRaw", 32'h104, pcRaw);
        waitCycle();
        checkEq("redirect", "flushed slot 0 valid", 32'd0, 32'(outValid[0]));
        checkEq("redirect", "flushed slot 1 valid", 32'd0, 32'(outValid[1]));
        waitCycle();
        checkBundle("redirect", 32'h100, 1'b0, 1'b1, NO_BRANCH_ID, NO_BRANCH_ID, 0, 0);

        waitCycle();
        checkBundle("jumpSlot1", 32'h108, 1'b1, 1'b1, NO_BRANCH_ID, branchIdFor(32'h10C), 0, 1);
        waitCycle();
        checkBundle("branchSlot0", 32'h140, 1'b1, 1'b0, branchIdFor(32'h140), NO_BRANCH_ID, 1, 0);
        waitCycle();
        checkBundle("twoBranches", 32'h1A0, 1'b1, 1'b0, branchIdFor(32'h1A0), NO_BRANCH_ID, 0, 0);
        waitCycle();
        checkBundle("twoBranches", 32'h1A0, 1'b0, 1'b1, NO_BRANCH_ID, branchIdFor(32'h1A4), 0, 0);

        expPc = 32'h1A8;
        for (int j = 0; j < 8; j++) begin
            waitCycle();
            checkBundle("stall", expPc, 1'b1, 1'b1, NO_BRANCH_ID, NO_BRANCH_ID, 0, 0);
            checkEq("stall", "pcRaw", expPc + 32'd16, pcRaw);
            stallLen = {$random(seed)} % 8;
            en0 = 1'b0;
            en1 = 1'b0;
            repeat (stallLen) begin
                waitCycle();
                checkBundle("stall", expPc, 1'b1, 1'b1, NO_BRANCH_ID, NO_BRANCH_ID, 0, 0);
                checkEq("stall", "pcRaw", expPc + 32'd16, pcRaw);
            end
            en0 = 1'b1;
            en1 = 1'b1;
            expPc = expPc + 32'd8;
        end

        waitCycle();
        if (u_FetchUnit.u_fetchChecks.failFlag) begin
            $display("a bound assertion failed before the end of the run");
            $display("TB FAILED");
            $fatal(1, "checker failure");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* tbFetch_assert.sv */
`timescale 1ns/10ps

module fetchChecks #(
    parameter int MEM_WORDS = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en0,
    input  logic                                en1,
    input  logic                                memWrite,
    input  logic [$clog2(MEM_WORDS)-1:0]        memAddr,
    input  logic [FetchPkg::BUNDLE_W-1:0]       memData,
    input  logic [FetchPkg::XLEN-1:0]           outPc [2],
    input  logic [FetchPkg::INSTR_W-1:0]        outInstr [2],
    input  logic [FetchPkg::BRANCH_ID_W-1:0]    outBranchId [2],
    input  logic                                outBranchPred [2],
    input  logic                                outValid [2]
);
    import FetchPkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [BUNDLE_W-1:0] shadow [MEM_WORDS];
    logic [1:0]          settleCnt;
    logic                ready;
    logic [XLEN-1:0]     prevPc;
    logic                failFlag = 1'b0;

    // mirror of the preloaded bundles
    always_ff @(posedge clk) begin
        if (memWrite) begin
            shadow[memAddr] <= memData;
        end
    end

    // outputs are defined after two edges with both enables
    always_ff @(posedge clk) begin
        if (rst) begin
            settleCnt <= 2'd0;
        end else if (en0 && en1 && settleCnt < 2'd2) begin
            settleCnt <= settleCnt + 2'd1;
        end
    end

    assign ready = (settleCnt == 2'd2);

    // pc of the bundle shown before the last output edge
    always_ff @(posedge clk) begin
        if (en1) begin
            prevPc <= outPc[0];
        end
    end

    // fall-through bundle is followed by the next aligned one
    bundleAdvances: assert property (@(posedge clk) disable iff (rst)
        ready && en1 && outValid[1] && !outBranchPred[1]
            |=> !(outValid[0] || outValid[1]) || (outPc[0] == prevPc + 32'd8))
    else begin
        failFlag = 1'b1;
        $error("next bundle pc: expected %h, actual %h", $sampled(prevPc) + 32'd8,
            $sampled(outPc[0]));
    end

    instrSlot0: assert property (@(posedge clk) disable iff (rst)
        ready && outValid[0] |-> outInstr[0] == shadow[outPc[0][3 +: AW]][31:0])
    else begin
        failFlag = 1'b1;
        $error("slot 0 instr at pc %h: expected %h, actual %h", $sampled(outPc[0]),
            shadow[$sampled(outPc[0][3 +: AW])][31:0], $sampled(outInstr[0]));
    end

    instrSlot1: assert property (@(posedge clk) disable iff (rst)
        ready && outValid[1] |-> outInstr[1] == shadow[outPc[1][3 +: AW]][63:32])
    else begin
        failFlag = 1'b1;
        $error("slot 1 instr at pc %h: expected %h, actual %h", $sampled(outPc[1]),
            shadow[$sampled(outPc[1][3 +: AW])][63:32], $sampled(outInstr[1]));
    end

    // a prediction always carries a real branch ID
    predHasId: assert property (@(posedge clk) disable iff (rst)
        ready |-> !(outValid[0] && outBranchPred[0] && outBranchId[0] == NO_BRANCH_ID)
            && !(outValid[1] && outBranchPred[1] && outBranchId[1] == NO_BRANCH_ID))
    else begin
        failFlag = 1'b1;
        $error("predicted slot carries the no-branch ID");
    end

    takenSlot0KillsSlot1: assert property (@(posedge clk) disable iff (rst)
        ready && outValid[0] && outBranchPred[0] |-> !outValid[1])
    else begin
        failFlag = 1'b1;
        $error("slot 1 valid behind a taken slot 0");
    end

    stallHolds: assert property (@(posedge clk) disable iff (rst)
        ready && !en1 |=> $stable(outPc[0]) && $stable(outInstr[0]) && $stable(outInstr[1])
            && $stable(outValid[0]) && $stable(outValid[1])
            && $stable(outBranchId[0]) && $stable(outBranchId[1]))
    else begin
        failFlag = 1'b1;
        $error("outputs changed while en1 was low");
    end

endmodule

bind FetchUnit fetchChecks #(
    .MEM_WORDS(MEM_WORDS)
) u_fetchChecks (
    .clk(clk),
    .rst(rst),
    .en0(en0),
    .en1(en1),
    .memWrite(memWrite),
    .memAddr(memAddr),
    .memData(memData),
    .outPc(outPc),
    .outInstr(outInstr),
    .outBranchId(outBranchId),
    .outBranchPred(outBranchPred),
    .outValid(outValid)
);
